//--- Makefile
# Verilator build and run of the control unit testbench

SIM     ?= verilator
TOP     ?= tb_cpu_ctrl
SEED    ?= 25
LOG     ?= sim.log
OBJ_DIR ?= obj_dir
FLIST   ?= project.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: SIM TOP SEED LOG OBJ_DIR FLIST"

test:
	$(SIM) --binary --assert -GSEED=$(SEED) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || echo "TEST FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cpu_ctrl.sv
module cpu_ctrl
    import ctrl_isa_pkg::*, ctrl_seq_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // fetch side
    input  opcode_t  opcode,
    input  logic     i_odv,
    input  logic     i_pending,
    input  logic     pc_w,
    output logic     i_req,
    output logic     int_ack,
    output logic     pc_load,
    output logic     alu_go,
    output alu_op_t  alu_op,
    output logic     illegal,
    output logic     ext_load,
    // memory side
    input  logic     d_odv,
    input  logic     hs_in,
    input  mem_cmd_t mem_cmd,
    output logic     d_req,
    output logic     d_we,
    output logic     hs_out,
    // write-back side
    input  wb_cmd_t  wb_cmd,
    output logic     reg_we,
    output logic     d_rdy
);

    ////////////////////
    // idle ring
    ////////////////////

    // fetch -> mem -> wb -> fetch
    logic fetch_idle;
    logic mem_idle;
    logic wb_idle;

    fetch_seq u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_odv      (i_odv),
        .i_pending  (i_pending),
        .pc_w       (pc_w),
        .opcode     (opcode),
        .wb_idle    (wb_idle),
        .i_req      (i_req),
        .pc_load    (pc_load),
        .int_ack    (int_ack),
        .alu_go     (alu_go),
        .illegal    (illegal),
        .ext_load   (ext_load),
        .fetch_idle (fetch_idle),
        .alu_op     (alu_op)
    );

    mem_seq u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_idle (fetch_idle),
        .d_rdy      (d_rdy),
        .d_odv      (d_odv),
        .hs_in      (hs_in),
        .mem_cmd    (mem_cmd),
        .d_req      (d_req),
        .d_we       (d_we),
        .hs_out     (hs_out),
        .mem_idle   (mem_idle)
    );

    // d_rdy also goes out to the datapath
    wb_seq u_wb (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_idle (mem_idle),
        .d_odv    (d_odv),
        .wb_cmd   (wb_cmd),
        .reg_we   (reg_we),
        .d_rdy    (d_rdy),
        .wb_idle  (wb_idle)
    );

endmodule

//--- ctrl_isa_pkg.sv
package ctrl_isa_pkg;

    ////////////////////
    // instruction word fields
    ////////////////////

    // opcode field width
    localparam int OPCODE_W = 6;

    // alu select width, opcode bits 4 down to 1
    localparam int ALU_OP_W = 4;

    // opcode bit that asks for an extension word
    localparam int EXT_BIT = 0;

    ////////////////////
    // field types
    ////////////////////

    // raw opcode as latched from the instruction word
    typedef logic [OPCODE_W-1:0] opcode_t;

    // alu operation select handed to the datapath
    typedef logic [ALU_OP_W-1:0] alu_op_t;

    ////////////////////
    // opcode map
    ////////////////////

    // 0o00 to 0o37 are alu operations
    // everything above is not implemented and flags illegal
    localparam opcode_t LAST_ALU_OPCODE = 6'o37;

endpackage

//--- ctrl_seq_pkg.sv
package ctrl_seq_pkg;

    ////////////////////
    // fetch stage states
    ////////////////////

    typedef enum logic [3:0] {
        F_IDLE,
        F_PC_LOAD,
        F_INT1,
        F_INT2,
        F_WAIT,
        F_DECODE,
        F_EXEC,
        F_EXT_WAIT,
        F_EXT
    } fetch_state_t;

    ////////////////////
    // memory stage
    ////////////////////

    typedef enum logic [2:0] {
        M_IDLE,
        M_DISPATCH,
        M_WAIT_RDY,
        M_XFER,
        M_PORT_WAIT,
        M_PORT_HOLD
    } mem_state_t;

    // command levels held by the datapath
    typedef logic [1:0] mem_cmd_t;

    localparam mem_cmd_t MC_NONE  = 2'd0;
    localparam mem_cmd_t MC_LOAD  = 2'd1;
    localparam mem_cmd_t MC_STORE = 2'd2;
    localparam mem_cmd_t MC_PORT  = 2'd3;

    ////////////////////
    // write-back stage
    ////////////////////

    typedef enum logic [1:0] {
        W_IDLE,
        W_DISPATCH,
        W_REG,
        W_MEM_WAIT
    } wb_state_t;

    // code 3 is spare and behaves as none
    typedef logic [1:0] wb_cmd_t;

    localparam wb_cmd_t WB_NONE = 2'd0;
    localparam wb_cmd_t WB_REG  = 2'd1;
    localparam wb_cmd_t WB_MEM  = 2'd2;

endpackage

//--- fetch_seq.sv
module fetch_seq
    import ctrl_isa_pkg::*, ctrl_seq_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    i_odv,
    input  logic    i_pending,
    input  logic    pc_w,
    input  opcode_t opcode,
    input  logic    wb_idle,
    output logic    i_req,
    output logic    pc_load,
    output logic    int_ack,
    output logic    alu_go,
    output logic    illegal,
    output logic    ext_load,
    output logic    fetch_idle,
    output alu_op_t alu_op
);

    fetch_state_t state;
    fetch_state_t next_state;

    // instruction register, opcode part only
    opcode_t ir;

    logic legal;
    logic needs_ext;

    ////////////////////
    // decode of latched opcode
    ////////////////////

    assign legal     = (ir <= LAST_ALU_OPCODE);
    assign needs_ext = legal && ir[EXT_BIT];
    assign alu_op    = ir[ALU_OP_W:1];

    ////////////////////
    // state register
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= F_IDLE;
        else
            state <= next_state;
    end

    // opcode captured on the accepting word
    always_ff @(posedge clk)
    begin
        if (state == F_WAIT && i_odv)
            ir <= opcode;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            F_IDLE:
            begin
                // write-back must be free before a new item starts
                if (wb_idle)
                begin
                    if (pc_w)
                        next_state = F_PC_LOAD;
                    else if (i_pending)
                        next_state = F_INT1;
                    else
                        next_state = F_WAIT;
                end
            end
            F_PC_LOAD:  next_state = i_pending ? F_INT1 : F_WAIT;
            F_INT1:     next_state = F_INT2;
            F_INT2:     next_state = F_WAIT;
            F_WAIT:     next_state = i_odv ? F_DECODE : F_WAIT;
            F_DECODE:   next_state = F_EXEC;
            F_EXEC:     next_state = needs_ext ? F_EXT_WAIT : F_IDLE;
            F_EXT_WAIT: next_state = i_odv ? F_EXT : F_EXT_WAIT;
            F_EXT:      next_state = F_IDLE;
            default:    next_state = F_IDLE;
        endcase
    end

    ////////////////////
    // moore outputs
    ////////////////////

    assign i_req      = (state == F_WAIT) || (state == F_EXT_WAIT);
    assign pc_load    = (state == F_PC_LOAD);
    assign int_ack    = (state == F_INT1) || (state == F_INT2);
    assign alu_go     = (state == F_EXEC) && legal;
    assign illegal    = (state == F_EXEC) && !legal;
    assign ext_load   = (state == F_EXT);
    assign fetch_idle = (state == F_IDLE);

    // one issue strobe per executed opcode
    a_issue_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_go && illegal))
        else $error("alu_go and illegal high together");

    // acknowledge is a two cycle pulse
    a_int_ack_len: assert property (@(posedge clk) disable iff (!rst_n)
        (state == F_INT1) |=> int_ack)
        else $error("int_ack shorter than two cycles");

endmodule

//--- mem_seq.sv
module mem_seq
    import ctrl_seq_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_idle,
    input  logic     d_rdy,
    input  logic     d_odv,
    input  logic     hs_in,
    input  mem_cmd_t mem_cmd,
    output logic     d_req,
    output logic     d_we,
    output logic     hs_out,
    output logic     mem_idle
);

    mem_state_t state;
    mem_state_t next_state;

    // command as seen in dispatch
    mem_cmd_t cmd;

    ////////////////////
    // state and command
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= M_IDLE;
            cmd   <= MC_NONE;
        end
        else
        begin
            state <= next_state;
            if (state == M_DISPATCH)
                cmd <= mem_cmd;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            M_IDLE:
            begin
                if (fetch_idle)
                    next_state = M_DISPATCH;
            end
            M_DISPATCH:
            begin
                case (mem_cmd)
                    MC_LOAD, MC_STORE: next_state = M_WAIT_RDY;
                    MC_PORT:           next_state = M_PORT_WAIT;
                    default:           next_state = M_IDLE;
                endcase
            end
            // write-back still waiting on memory data
            M_WAIT_RDY:  next_state = d_rdy ? M_XFER : M_WAIT_RDY;
            M_XFER:      next_state = d_odv ? M_IDLE : M_XFER;
            // two phase exchange with the port partner
            M_PORT_WAIT: next_state = hs_in ? M_PORT_HOLD : M_PORT_WAIT;
            M_PORT_HOLD: next_state = hs_in ? M_PORT_HOLD : M_IDLE;
            default:     next_state = M_IDLE;
        endcase
    end

    ////////////////////
    // outputs
    ////////////////////

    assign d_req    = (state == M_XFER);
    assign d_we     = d_req && (cmd == MC_STORE);
    assign hs_out   = (state == M_PORT_HOLD);
    assign mem_idle = (state == M_IDLE);

    // port exchange and data transfer are separate items
    a_port_xfer_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(hs_out && d_req))
        else $error("hs_out and d_req high together");

    a_we_in_xfer: assert property (@(posedge clk) disable iff (!rst_n)
        d_we |-> d_req)
        else $error("d_we without d_req");

endmodule

//--- project.f
ctrl_isa_pkg.sv
ctrl_seq_pkg.sv
fetch_seq.sv
mem_seq.sv
wb_seq.sv
cpu_ctrl.sv
tb_cpu_ctrl.sv

//--- tb_cpu_ctrl.sv
module tb_cpu_ctrl
    import ctrl_isa_pkg::*, ctrl_seq_pkg::*;
#(
    parameter int SEED = 25
);

    localparam int CYCLE_LIMIT = 6 * 400 + 10;

    logic clk, rst_n, i_odv, i_pending, pc_w, d_odv, hs_in;
    opcode_t opcode;
    mem_cmd_t mem_cmd;
    wb_cmd_t wb_cmd;
    logic i_req, int_ack, pc_load, alu_go, illegal, ext_load;
    logic d_req, d_we, hs_out, reg_we, d_rdy;
    alu_op_t alu_op;

    integer seed;
    int errors = 0;
    int passed = 0;
    int failed = 0;
    int cycles = 0;
    int p_odv, p_pend, p_pcw, p_dodv, p_hs, p_ill, p_port;
    logic force_odd;

    // reference model state
    opcode_t ref_op;
    mem_cmd_t xfer_cmd;
    mem_cmd_t cur_cmd;
    logic [1:0] issue_pipe;
    logic ext_wait, ext_accept_q, d_req_q;
    logic reset_seen = 1'b0;
    logic outs_idle;
    int n_issue = 0;
    int n_ext = 0;
    int n_int = 0;
    int n_xfer = 0;
    int n_port = 0;

    cpu_ctrl uut (
        .clk(clk), .rst_n(rst_n), .opcode(opcode), .i_odv(i_odv),
        .i_pending(i_pending), .pc_w(pc_w), .i_req(i_req), .int_ack(int_ack),
        .pc_load(pc_load), .alu_go(alu_go), .alu_op(alu_op), .illegal(illegal),
        .ext_load(ext_load), .d_odv(d_odv), .hs_in(hs_in), .mem_cmd(mem_cmd),
        .d_req(d_req), .d_we(d_we), .hs_out(hs_out), .wb_cmd(wb_cmd),
        .reg_we(reg_we), .d_rdy(d_rdy)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // reference tracking
    ////////////////////

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (!rst_n)
        begin
            reset_seen   <= 1'b1;
            issue_pipe   <= 2'b00;
            ext_wait     <= 1'b0;
            ext_accept_q <= 1'b0;
            d_req_q      <= 1'b0;
            xfer_cmd     <= MC_NONE;
        end
        else
        begin
            // i_req in the extension wait is not a new fetch
            if (i_req && i_odv && !ext_wait)
                ref_op <= opcode;
            issue_pipe   <= {issue_pipe[0], i_req && i_odv && !ext_wait};
            ext_accept_q <= i_req && i_odv && ext_wait;
            if (alu_go && ref_op[EXT_BIT])
                ext_wait <= 1'b1;
            else if (i_req && i_odv)
                ext_wait <= 1'b0;
            d_req_q <= d_req;
            if (d_req && !d_req_q)
                xfer_cmd <= mem_cmd;
            n_issue <= n_issue + int'(alu_go);
            n_ext   <= n_ext + int'(ext_load);
            n_int   <= n_int + int'(int_ack);
            n_xfer  <= n_xfer + int'(d_we);
            n_port  <= n_port + int'(hs_out);
        end
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // command seen on the first d_req cycle
    assign cur_cmd   = d_req_q ? xfer_cmd : mem_cmd;
    assign outs_idle = d_rdy && !(i_req || pc_load || int_ack || alu_go || illegal
                       || ext_load || d_req || d_we || hs_out || reg_we);

    ////////////////////
    // checks
    ////////////////////

    a_reset_idle: assert property (@(posedge clk)
        ((reset_seen && !rst_n) || $rose(rst_n)) |-> outs_idle)
        else note_error("control outputs not idle around reset");
    a_issue_due: assert property (@(posedge clk) disable iff (!rst_n)
        issue_pipe[1] |-> (alu_go ^ illegal))
        else note_error("no single issue strobe 2 cycles after fetch");
    a_issue_only: assert property (@(posedge clk) disable iff (!rst_n)
        (alu_go || illegal) |-> issue_pipe[1])
        else note_error("issue strobe without a fetch 2 cycles before");
    a_alu_legal: assert property (@(posedge clk) disable iff (!rst_n)
        alu_go |-> (ref_op <= LAST_ALU_OPCODE && alu_op == ref_op[ALU_OP_W:1]))
        else note_error("alu_go with wrong opcode or alu_op");
    a_illegal_op: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> (ref_op > LAST_ALU_OPCODE))
        else note_error("illegal raised for an alu opcode");
    a_ext_req: assert property (@(posedge clk) disable iff (!rst_n)
        ext_wait |-> i_req)
        else note_error("i_req dropped while waiting for extension");
    a_ext_due: assert property (@(posedge clk) disable iff (!rst_n)
        ext_accept_q |-> ext_load)
        else note_error("ext_load missing 1 cycle after extension word");
    a_ext_only: assert property (@(posedge clk) disable iff (!rst_n)
        ext_load |-> ext_accept_q)
        else note_error("ext_load without an extension word");
    a_int_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(int_ack) |=> int_ack)
        else note_error("int_ack shorter than 2 cycles");
    a_int_end: assert property (@(posedge clk) disable iff (!rst_n)
        (int_ack && $past(int_ack)) |=> !int_ack)
        else note_error("int_ack longer than 2 cycles");
    a_pc_next: assert property (@(posedge clk) disable iff (!rst_n)
        pc_load |=> (int_ack || i_req))
        else note_error("pc_load not followed by int_ack or i_req");
    a_req_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(d_req) |-> d_rdy)
        else note_error("d_req rose while d_rdy low");
    a_store_we: assert property (@(posedge clk) disable iff (!rst_n)
        d_req |-> (d_we == (cur_cmd == MC_STORE)))
        else note_error("d_we does not match the latched command");
    a_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
        (d_req && d_odv) |=> !d_req)
        else note_error("d_req still high after d_odv");
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (d_req && !d_odv) |=> d_req)
        else note_error("d_req dropped before d_odv");
    a_hs_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(hs_out) |-> $past(hs_in))
        else note_error("hs_out rose without hs_in");
    a_hs_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (hs_out && hs_in) |=> hs_out)
        else note_error("hs_out dropped while hs_in high");
    a_hs_fall: assert property (@(posedge clk) disable iff (!rst_n)
        (hs_out && !hs_in) |=> !hs_out)
        else note_error("hs_out still high after hs_in low");
    a_reg_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        reg_we |=> !reg_we)
        else note_error("reg_we lasted 2 cycles");

    task automatic note_error(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    function automatic bit chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    task automatic set_bias(input int odv, input int pend, input int pcw, input int dodv,
                            input int hs, input int ill, input int port, input logic odd);
        p_odv  = odv;
        p_pend = pend;
        p_pcw  = pcw;
        p_dodv = dodv;
        p_hs   = hs;
        p_ill  = ill;
        p_port = port;
        force_odd = odd;
    endtask

    // one falling edge worth of datapath levels
    task automatic drive_inputs;
        i_odv     = chance(p_odv);
        i_pending = chance(p_pend);
        pc_w      = chance(p_pcw);
        d_odv     = chance(p_dodv);
        hs_in     = chance(p_hs);
        wb_cmd    = wb_cmd_t'($random(seed));
        opcode    = {chance(p_ill), 5'($random(seed))};
        if (force_odd)
            opcode[EXT_BIT] = 1'b1;
        // datapath only swaps the command when the stage cannot be latching it
        if (mem_cmd == MC_NONE || hs_out || (d_req && d_req_q))
        begin
            if (chance(10))
                mem_cmd = MC_NONE;
            else if (chance(p_port))
                mem_cmd = MC_PORT;
            else
                mem_cmd = chance(50) ? MC_STORE : MC_LOAD;
        end
    endtask

    function automatic int target_count(input int idx);
        case (idx)
            1:       return n_issue;
            2:       return n_ext;
            3:       return n_int;
            4:       return n_xfer;
            default: return n_port;
        endcase
    endfunction

    task automatic run_test(input string name, input int idx, input int len);
        int err0;
        int hit0;
        err0 = errors;
        hit0 = target_count(idx);
        repeat (len)
        begin
            @(negedge clk);
            drive_inputs();
        end
        if (idx > 0 && target_count(idx) == hit0)
        begin
            errors++;
            $display("test %s never reached the behavior it targets", name);
        end
        if (errors == err0)
            passed++;
        else
            failed++;
        $display("test %0d %s: %s", idx + 1, name, (errors == err0) ? "ok" : "errors");
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial
    begin
        seed = SEED;
        rst_n = 1'b0;
        {i_odv, i_pending, pc_w, d_odv, hs_in} = '0;
        opcode = '0;
        mem_cmd = MC_NONE;
        wb_cmd = WB_NONE;
        set_bias(50, 0, 0, 50, 0, 0, 0, 1'b0);
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        run_test("reset", 0, 40);
        set_bias(60, 5, 5, 50, 30, 40, 20, 1'b0);
        run_test("alu issue", 1, 300);
        set_bias(40, 5, 5, 50, 30, 10, 20, 1'b1);
        run_test("extension word", 2, 300);
        set_bias(50, 50, 40, 50, 30, 20, 20, 1'b0);
        run_test("interrupt and pc load", 3, 300);
        set_bias(60, 5, 5, 40, 20, 20, 0, 1'b0);
        run_test("memory transfer", 4, 300);
        set_bias(60, 5, 5, 50, 40, 20, 80, 1'b0);
        run_test("port exchange", 5, 300);
        $display("tests passed %0d failed %0d", passed, failed);
        if (failed == 0 && errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- wb_seq.sv
module wb_seq
    import ctrl_seq_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    mem_idle,
    input  logic    d_odv,
    input  wb_cmd_t wb_cmd,
    output logic    reg_we,
    output logic    d_rdy,
    output logic    wb_idle
);

    wb_state_t state;
    wb_state_t next_state;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= W_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            W_IDLE:
            begin
                if (mem_idle)
                    next_state = W_DISPATCH;
            end
            W_DISPATCH:
            begin
                // spare code falls through to idle
                case (wb_cmd)
                    WB_REG:  next_state = W_REG;
                    WB_MEM:  next_state = W_MEM_WAIT;
                    default: next_state = W_IDLE;
                endcase
            end
            W_REG:      next_state = W_IDLE;
            W_MEM_WAIT: next_state = d_odv ? W_IDLE : W_MEM_WAIT;
            default:    next_state = W_IDLE;
        endcase
    end

    ////////////////////
    // outputs
    ////////////////////

    assign reg_we  = (state == W_REG);
    // low only while waiting on memory data
    assign d_rdy   = (state != W_MEM_WAIT);
    assign wb_idle = (state == W_IDLE);

    a_reg_we_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        reg_we |=> !reg_we)
        else $error("reg_we held for two cycles");

endmodule
